/* cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data word width
`define CPU_XLEN 32

// Memory address width, word addressed
`define CPU_ADDR_W 16

// Register file depth
`define CPU_REG_CNT 16

// Length of the one-hot step ring
`define CPU_STEPS 5

// First fetch address after reset
`define CPU_RESET_PC 16'h0000

`endif

/* cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

    // Register index width, 4 bits for 16 registers
    localparam int REG_W = $clog2(`CPU_REG_CNT);

    // Opcode map of the kept instructions
    typedef enum logic [4:0] {
        OP_LD   = 5'b00000,
        OP_LI   = 5'b00001,
        OP_ST   = 5'b00010,
        OP_ADD  = 5'b00011,
        OP_SUB  = 5'b00100,
        OP_AND  = 5'b00101,
        OP_OR   = 5'b00110,
        OP_ROR  = 5'b00111,
        OP_ROL  = 5'b01000,
        OP_SRL  = 5'b01001,
        OP_SRA  = 5'b01010,
        OP_SLL  = 5'b01011,
        OP_ADDI = 5'b01100,
        OP_ANDI = 5'b01101,
        OP_ORI  = 5'b01110,
        OP_NEG  = 5'b10001,
        OP_NOT  = 5'b10010,
        OP_BR   = 5'b10011,
        OP_JR   = 5'b10100,
        OP_JAL  = 5'b10101,
        OP_NOP  = 5'b11010,
        OP_HLT  = 5'b11011
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_ROR, ALU_ROL, ALU_NOT, ALU_NEG, ALU_PASSB
    } aluOpE;

    // Branch condition, tested against operand A flags
    typedef enum logic [1:0] {
        BR_ZERO  = 2'b00,
        BR_NZERO = 2'b01,
        BR_POS   = 2'b10,
        BR_NEG   = 2'b11
    } brCondE;

    // Four views of one instruction word
    typedef struct packed {
        opcodeE opcode;
        logic [REG_W-1:0] ra;
        logic [REG_W-1:0] rb;
        logic [REG_W-1:0] rc;
        logic [`CPU_XLEN-6-3*REG_W:0] pad;
    } rFmtS;

    typedef struct packed {
        opcodeE opcode;
        logic [REG_W-1:0] ra;
        logic [REG_W-1:0] rb;
        logic [`CPU_XLEN-6-2*REG_W:0] imm;
    } iFmtS;

    typedef struct packed {
        opcodeE opcode;
        logic [REG_W-1:0] ra;
        brCondE cond;
        logic [1:0] pad;
        logic [`CPU_XLEN-10-REG_W:0] offset;
    } bFmtS;

    typedef struct packed {
        opcodeE opcode;
        logic [REG_W-1:0] ra;
        logic [`CPU_XLEN-6-REG_W:0] pad;
    } jFmtS;

    typedef union packed {
        rFmtS r;
        iFmtS i;
        bFmtS b;
        jFmtS j;
    } instrU;

    typedef struct packed {
        opcodeE opcode;
        logic [REG_W-1:0] ra;
        logic [REG_W-1:0] rb;
        logic [REG_W-1:0] rc;
        brCondE cond;
        logic [`CPU_XLEN-1:0] imm32;
        logic isR;
        logic isI;
        logic isB;
        logic isJ;
        logic isM;
    } decodedS;

    // Control word to the datapath
    typedef struct packed {
        logic pcLoad;
        logic pcSelReg;
        logic pcSelBranch;
        logic opALoad;
        logic opBLoad;
        logic immSel;
        aluOpE aluOp;
        logic resLoad;
        logic marLoad;
        logic addrSelRes;
        logic mdrLoad;
        logic rfWrite;
        logic wbSelMem;
        logic [REG_W-1:0] rdAddrA;
        logic [REG_W-1:0] rdAddrB;
        logic [REG_W-1:0] wrAddr;
    } ctrlS;

    // Both flags come from operand A
    typedef struct packed {
        logic zero;
        logic neg;
    } flagsS;

endpackage

/* cpuDecode.sv */
`timescale 1ns/1ps

module cpuDecode (
    input  cpu_pkg::instrU   instr,
    output cpu_pkg::decodedS dec
);

    always_comb begin
        dec = '0;
        // Fields common to every format
        dec.opcode = instr.r.opcode;
        dec.ra = instr.r.ra;
        dec.rb = instr.i.rb;
        dec.rc = instr.r.rc;
        dec.cond = instr.b.cond;

        case (instr.r.opcode)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
            cpu_pkg::OP_OR, cpu_pkg::OP_SLL, cpu_pkg::OP_SRL,
            cpu_pkg::OP_SRA, cpu_pkg::OP_ROR, cpu_pkg::OP_ROL: begin
                dec.isR = 1'b1;
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI,
            cpu_pkg::OP_NOT, cpu_pkg::OP_NEG, cpu_pkg::OP_LD,
            cpu_pkg::OP_LI, cpu_pkg::OP_ST: begin
                dec.isI = 1'b1;
                // Sign extend 19-bit immediate
                dec.imm32 = $signed(instr.i.imm);
            end
            cpu_pkg::OP_BR: begin
                dec.isB = 1'b1;
                // Branch offset read through its own view
                dec.imm32 = $signed(instr.b.offset);
            end
            cpu_pkg::OP_JAL, cpu_pkg::OP_JR: begin
                dec.isJ = 1'b1;
            end
            cpu_pkg::OP_NOP, cpu_pkg::OP_HLT: begin
                dec.isM = 1'b1;
            end
            default: begin
                // Unknown opcode behaves as NOP
                dec.opcode = cpu_pkg::OP_NOP;
                dec.isM = 1'b1;
            end
        endcase
    end

endmodule

/* cpuAlu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuAlu (
    input  cpu_pkg::aluOpE       op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] y
);

    // Shift amount from low bits of b
    logic [$clog2(`CPU_XLEN)-1:0] sh;
    // Doubled word for rotates
    logic [2*`CPU_XLEN-1:0] rotR;
    logic [2*`CPU_XLEN-1:0] rotL;

    assign sh = b[$clog2(`CPU_XLEN)-1:0];
    assign rotR = {a, a} >> sh;
    assign rotL = {a, a} << sh;

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:   y = a + b;
            cpu_pkg::ALU_SUB:   y = a - b;
            cpu_pkg::ALU_AND:   y = a & b;
            cpu_pkg::ALU_OR:    y = a | b;
            cpu_pkg::ALU_SLL:   y = a << sh;
            cpu_pkg::ALU_SRL:   y = a >> sh;
            // Sign bit fills from the left
            cpu_pkg::ALU_SRA:   y = $signed(a) >>> sh;
            // Low half of the right-shifted pair
            cpu_pkg::ALU_ROR:   y = rotR[`CPU_XLEN-1:0];
            // High half of the left-shifted pair
            cpu_pkg::ALU_ROL:   y = rotL[2*`CPU_XLEN-1:`CPU_XLEN];
            // Unary ops act on a only
            cpu_pkg::ALU_NOT:   y = ~a;
            cpu_pkg::ALU_NEG:   y = -a;
            cpu_pkg::ALU_PASSB: y = b;
            default:            y = '0;
        endcase
    end

endmodule

/* cpuRegFile.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuRegFile (
    input  logic                      iClk,
    input  logic                      nRst,
    input  logic [cpu_pkg::REG_W-1:0] rdAddrA,
    input  logic [cpu_pkg::REG_W-1:0] rdAddrB,
    output logic [`CPU_XLEN-1:0]      rdDataA,
    output logic [`CPU_XLEN-1:0]      rdDataB,
    input  logic                      wrEn,
    input  logic [cpu_pkg::REG_W-1:0] wrAddr,
    input  logic [`CPU_XLEN-1:0]      wrData
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_CNT];

    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            for (int i = 0; i < `CPU_REG_CNT; i++)
                regs[i] <= '0;
        end else if (wrEn && wrAddr != '0) begin
            // R0 never written, stays zero
            regs[wrAddr] <= wrData;
        end
    end

    // Combinational read ports
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

/* cpuControl.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuControl (
    input  logic                 iClk,
    input  logic                 nRst,
    input  logic                 memRdy,
    input  logic [`CPU_XLEN-1:0] memRData,
    input  cpu_pkg::flagsS       flags,
    output cpu_pkg::ctrlS        ctrl,
    output logic [`CPU_XLEN-1:0] imm32,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 halted
);

    // One-hot ring, bit 0 is fetch, bit 4 write back
    logic [`CPU_STEPS-1:0] step;
    cpu_pkg::instrU ir;
    cpu_pkg::decodedS dec;
    logic advance;
    logic brTaken;
    logic isLd;
    logic isSt;

    // Ring only moves on ready, frozen once halted
    assign advance = memRdy && !halted;

    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            step <= {{(`CPU_STEPS-1){1'b0}}, 1'b1};
            ir <= '0;
            halted <= 1'b0;
        end else if (advance) begin
            step <= {step[`CPU_STEPS-2:0], step[`CPU_STEPS-1]};
            if (step[0])
                ir <= memRData;
            // HLT takes effect in the ALU step
            if (step[2] && dec.opcode == cpu_pkg::OP_HLT)
                halted <= 1'b1;
        end
    end

    cpuDecode cpuDecode_inst (
        .instr(ir),
        .dec  (dec)
    );

    assign isLd = (dec.opcode == cpu_pkg::OP_LD);
    assign isSt = (dec.opcode == cpu_pkg::OP_ST);
    assign imm32 = dec.imm32;

    // Each condition code tests its own flag
    always_comb begin
        case (dec.cond)
            cpu_pkg::BR_ZERO:  brTaken = flags.zero;
            cpu_pkg::BR_NZERO: brTaken = !flags.zero;
            // Positive means strictly above zero
            cpu_pkg::BR_POS:   brTaken = !flags.neg && !flags.zero;
            default:           brTaken = flags.neg;
        endcase
        brTaken = brTaken && dec.isB;
    end

    always_comb begin
        ctrl = '0;
        // Read ports by format; B and J read ra on port A
        ctrl.rdAddrA = (dec.isR || dec.isI) ? dec.rb : dec.ra;
        ctrl.rdAddrB = dec.isR ? dec.rc : dec.ra;
        ctrl.wrAddr = dec.ra;
        ctrl.immSel = dec.isI;
        ctrl.wbSelMem = isLd;

        case (dec.opcode)
            cpu_pkg::OP_SUB:                  ctrl.aluOp = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND, cpu_pkg::OP_ANDI: ctrl.aluOp = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR, cpu_pkg::OP_ORI:   ctrl.aluOp = cpu_pkg::ALU_OR;
            cpu_pkg::OP_SLL:                  ctrl.aluOp = cpu_pkg::ALU_SLL;
            cpu_pkg::OP_SRL:                  ctrl.aluOp = cpu_pkg::ALU_SRL;
            cpu_pkg::OP_SRA:                  ctrl.aluOp = cpu_pkg::ALU_SRA;
            cpu_pkg::OP_ROR:                  ctrl.aluOp = cpu_pkg::ALU_ROR;
            cpu_pkg::OP_ROL:                  ctrl.aluOp = cpu_pkg::ALU_ROL;
            cpu_pkg::OP_NOT:                  ctrl.aluOp = cpu_pkg::ALU_NOT;
            cpu_pkg::OP_NEG:                  ctrl.aluOp = cpu_pkg::ALU_NEG;
            // Link value passes through on port B
            cpu_pkg::OP_JAL:                  ctrl.aluOp = cpu_pkg::ALU_PASSB;
            // Address and LI sums use ADD too
            default:                          ctrl.aluOp = cpu_pkg::ALU_ADD;
        endcase

        // Step 1, PC increment
        ctrl.pcLoad = step[0] || (step[2] && (brTaken || dec.isJ));
        // Step 2, operand fetch
        ctrl.opALoad = step[1] && !dec.isM;
        ctrl.opBLoad = step[1] && (dec.isR || isSt);
        // Step 3, ALU or branch
        ctrl.pcSelReg = step[2] && dec.isJ;
        ctrl.pcSelBranch = step[2] && brTaken;
        ctrl.resLoad = step[2] && (dec.isR || dec.isI || dec.opcode == cpu_pkg::OP_JAL);
        ctrl.marLoad = step[2] && (isLd || isSt);
        // Step 4, memory
        ctrl.addrSelRes = step[3] && (isLd || isSt);
        ctrl.mdrLoad = step[3] && isLd;
        // Step 5, write back
        ctrl.rfWrite = step[4] && (dec.isR || (dec.isI && !isSt)
                                   || dec.opcode == cpu_pkg::OP_JAL);
    end

    // Strobes held through a stalled step
    assign memRead = !halted && (step[0] || (step[3] && isLd));
    assign memWrite = !halted && step[3] && isSt;

endmodule

/* cpuDatapath.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuDatapath (
    input  logic                   iClk,
    input  logic                   nRst,
    input  logic                   memRdy,
    input  cpu_pkg::ctrlS          ctrl,
    input  logic [`CPU_XLEN-1:0]   imm32,
    input  logic [`CPU_XLEN-1:0]   memRData,
    output cpu_pkg::flagsS         flags,
    output logic [`CPU_ADDR_W-1:0] memAddr,
    output logic [`CPU_XLEN-1:0]   memWData
);

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] pcNext;
    logic [`CPU_ADDR_W-1:0] mar;
    logic [`CPU_XLEN-1:0] opA;
    logic [`CPU_XLEN-1:0] opB;
    logic [`CPU_XLEN-1:0] res;
    logic [`CPU_XLEN-1:0] mdr;
    logic [`CPU_XLEN-1:0] rdDataA;
    logic [`CPU_XLEN-1:0] rdDataB;
    logic [`CPU_XLEN-1:0] aluB;
    logic [`CPU_XLEN-1:0] aluY;
    logic [`CPU_XLEN-1:0] wbData;

    // PC source: register jump, relative branch or increment
    assign pcNext = ctrl.pcSelReg    ? opA[`CPU_ADDR_W-1:0] :
                    ctrl.pcSelBranch ? pc + imm32[`CPU_ADDR_W-1:0] :
                    pc + 1'b1;

    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst)
            pc <= `CPU_RESET_PC;
        else if (memRdy && ctrl.pcLoad)
            pc <= pcNext;
    end

    // Payload registers, each load qualified by ready
    always_ff @(posedge iClk) begin
        if (memRdy) begin
            if (ctrl.opALoad) opA <= rdDataA;
            if (ctrl.opBLoad) opB <= rdDataB;
            if (ctrl.resLoad) res <= aluY;
            if (ctrl.marLoad) mar <= aluY[`CPU_ADDR_W-1:0];
            if (ctrl.mdrLoad) mdr <= memRData;
        end
    end

    // Return PC on port B during JAL, else immediate or operand B
    assign aluB = ctrl.pcSelReg ? {{(`CPU_XLEN-`CPU_ADDR_W){1'b0}}, pc} :
                  ctrl.immSel   ? imm32 : opB;
    assign wbData = ctrl.wbSelMem ? mdr : res;

    cpuRegFile cpuRegFile_inst (
        .iClk   (iClk),
        .nRst   (nRst),
        .rdAddrA(ctrl.rdAddrA),
        .rdAddrB(ctrl.rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn   (memRdy && ctrl.rfWrite),
        .wrAddr (ctrl.wrAddr),
        .wrData (wbData)
    );

    cpuAlu cpuAlu_inst (
        .op(ctrl.aluOp),
        .a (opA),
        .b (aluB),
        .y (aluY)
    );

    // Data address during the memory step, PC otherwise
    assign memAddr = ctrl.addrSelRes ? mar : pc;
    assign memWData = opB;
    assign flags.zero = (opA == '0);
    assign flags.neg = opA[`CPU_XLEN-1];

endmodule

/* cpuCore.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuCore (
    input  logic                   iClk,
    input  logic                   nRst,
    input  logic                   memRdy,
    input  logic [`CPU_XLEN-1:0]   memRData,
    output logic [`CPU_ADDR_W-1:0] memAddr,
    output logic [`CPU_XLEN-1:0]   memWData,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   halted
);

    // Control word and immediate toward the datapath
    cpu_pkg::ctrlS ctrl;
    logic [`CPU_XLEN-1:0] imm32;
    // Operand A flags back to branch resolution
    cpu_pkg::flagsS flags;

    cpuControl cpuControl_inst (
        .iClk    (iClk),
        .nRst    (nRst),
        .memRdy  (memRdy),
        .memRData(memRData),
        .flags   (flags),
        .ctrl    (ctrl),
        .imm32   (imm32),
        .memRead (memRead),
        .memWrite(memWrite),
        .halted  (halted)
    );

    cpuDatapath cpuDatapath_inst (
        .iClk    (iClk),
        .nRst    (nRst),
        .memRdy  (memRdy),
        .ctrl    (ctrl),
        .imm32   (imm32),
        .memRData(memRData),
        .flags   (flags),
        .memAddr (memAddr),
        .memWData(memWData)
    );

endmodule

/* cpuCore_props.sv */
`timescale 1ns/1ps

module cpuCore_props (
    input logic iClk,
    input logic nRst,
    input logic memRead,
    input logic memWrite,
    input logic halted
);

    // Read and write strobes are exclusive
    assert property (@(posedge iClk) disable iff (!nRst) !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    // Bus stays quiet once halted
    assert property (@(posedge iClk) disable iff (!nRst) halted |-> !memRead && !memWrite)
        else $error("memory strobe while halted");

    // Only reset clears halted
    assert property (@(posedge iClk) disable iff (!nRst) halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind cpuCore cpuCore_props cpuCore_props_inst (
    .iClk    (iClk),
    .nRst    (nRst),
    .memRead (memRead),
    .memWrite(memWrite),
    .halted  (halted)
);

/* cpuCore_checker.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuCore_checker (
    input  logic                   iClk,
    input  logic                   nRst,
    input  logic                   memRdy,
    input  logic                   memRead,
    input  logic                   memWrite,
    input  logic [`CPU_ADDR_W-1:0] memAddr,
    input  logic [`CPU_XLEN-1:0]   memWData,
    input  logic                   halted,
    output int                     valueErrs,
    output int                     otherErrs,
    output logic                   done
);

    // Pending stores, oldest first
    logic [`CPU_ADDR_W-1:0] expAddrQ [$];
    logic [`CPU_XLEN-1:0] expDataQ [$];
    logic [`CPU_ADDR_W-1:0] wantAddr;
    logic [`CPU_XLEN-1:0] wantData;
    logic haltedPrev;

    task automatic expectStore(input logic [`CPU_ADDR_W-1:0] addr,
                               input logic [`CPU_XLEN-1:0] data);
        expAddrQ.push_back(addr);
        expDataQ.push_back(data);
    endtask

    always @(posedge iClk) begin
        // A write lands only with ready high
        if (nRst && memWrite && memRdy) begin
            if (expAddrQ.size() == 0) begin
                $display("%0t: store of %h to address %h was not expected",
                         $time, memWData, memAddr);
                otherErrs++;
            end else begin
                wantAddr = expAddrQ.pop_front();
                wantData = expDataQ.pop_front();
                if (memAddr !== wantAddr) begin
                    $display("[ERROR] %0t memAddr expected %h got %h", $time, wantAddr, memAddr);
                    valueErrs++;
                end
                if (memWData !== wantData) begin
                    $display("[ERROR] %0t memWData expected %h got %h", $time, wantData, memWData);
                    valueErrs++;
                end
            end
        end
        if (nRst && memRead && memWrite) begin
            $display("%0t: read and write strobes were high together", $time);
            otherErrs++;
        end
        if (nRst && halted && (memRead || memWrite)) begin
            $display("%0t: memory strobe seen after the core halted", $time);
            otherErrs++;
        end
        if (nRst && haltedPrev && !halted) begin
            $display("%0t: halted dropped while reset was inactive", $time);
            otherErrs++;
        end
        haltedPrev = halted;
    end

    initial begin
        valueErrs = 0;
        otherErrs = 0;
        done = 1'b0;
        haltedPrev = 1'b0;
        wait (halted === 1'b1);
        // Watch a while longer for stray strobes
        repeat (20) @(posedge iClk);
        if (expAddrQ.size() != 0) begin
            $display("%0d expected stores never happened", expAddrQ.size());
            otherErrs += expAddrQ.size();
        end
        done = 1'b1;
    end

endmodule

/* cpuCore_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuCore_tb;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;

    // One table row holds a program word and the store it should cause
    typedef struct packed {
        logic [`CPU_XLEN-1:0] instr;
        logic chk;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_XLEN-1:0] data;
    } progEntryS;

    logic iClk;
    logic nRst;
    logic memRdy;
    logic [`CPU_XLEN-1:0] memRData;
    logic [`CPU_ADDR_W-1:0] memAddr;
    logic [`CPU_XLEN-1:0] memWData;
    logic memRead;
    logic memWrite;
    logic halted;
    int valueErrs;
    int otherErrs;
    logic checkDone;

    progEntryS prog [$];
    logic [`CPU_XLEN-1:0] mem [0:(1 << `CPU_ADDR_W)-1];
    logic [31:0] lfsr;
    logic [1:0] phase;
    longint runLimit;

    // Instruction encoders with the field layout of each format
    function automatic logic [31:0] encR(cpu_pkg::opcodeE op, int ra, int rb, int rc);
        encR = {op, 4'(ra), 4'(rb), 4'(rc), 15'b0};
    endfunction

    function automatic logic [31:0] encI(cpu_pkg::opcodeE op, int ra, int rb, int imm);
        encI = {op, 4'(ra), 4'(rb), 19'(imm)};
    endfunction

    // Target is the word after the branch plus offset
    function automatic logic [31:0] encB(cpu_pkg::brCondE cond, int ra, int off);
        encB = {cpu_pkg::OP_BR, 4'(ra), cond, 2'b00, 19'(off)};
    endfunction

    function automatic logic [31:0] encJ(cpu_pkg::opcodeE op, int ra);
        encJ = {op, 4'(ra), 23'b0};
    endfunction

    // Background word unique to each address
    function automatic logic [31:0] fillWord(input logic [15:0] a);
        fillWord = {~a, a};
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        lfsrStep = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic addInstr(input logic [31:0] instr);
        prog.push_back({instr, 1'b0, 16'h0, 32'h0});
    endtask

    // ST ra to an absolute address with R0 as base
    task automatic addStore(input int ra, input int addr, input logic chk,
                            input logic [31:0] data);
        prog.push_back({encI(cpu_pkg::OP_ST, ra, 0, addr), chk, 16'(addr), data});
    endtask

    task automatic buildProgram();
        int jalAt;
        // R1 is positive and R2 negative and R3 holds the shift amount
        addInstr(encI(cpu_pkg::OP_LI, 1, 0, 'h12346));
        addInstr(encI(cpu_pkg::OP_LI, 2, 0, -3));
        addInstr(encI(cpu_pkg::OP_LI, 3, 0, 8));
        addInstr(encR(cpu_pkg::OP_ADD, 4, 1, 2));
        addStore(4, 'h200, 1'b1, 32'h0001_2343);
        addInstr(encR(cpu_pkg::OP_SUB, 4, 1, 2));
        addStore(4, 'h201, 1'b1, 32'h0001_2349);
        addInstr(encR(cpu_pkg::OP_AND, 4, 1, 2));
        addStore(4, 'h202, 1'b1, 32'h0001_2344);
        addInstr(encR(cpu_pkg::OP_OR, 4, 1, 3));
        addStore(4, 'h203, 1'b1, 32'h0001_234E);
        addInstr(encR(cpu_pkg::OP_SLL, 4, 1, 3));
        addStore(4, 'h204, 1'b1, 32'h0123_4600);
        addInstr(encR(cpu_pkg::OP_SRL, 4, 2, 3));
        addStore(4, 'h205, 1'b1, 32'h00FF_FFFF);
        addInstr(encR(cpu_pkg::OP_SRA, 4, 2, 3));
        addStore(4, 'h206, 1'b1, 32'hFFFF_FFFF);
        addInstr(encR(cpu_pkg::OP_ROR, 4, 1, 3));
        addStore(4, 'h207, 1'b1, 32'h4600_0123);
        addInstr(encR(cpu_pkg::OP_ROL, 4, 2, 3));
        addStore(4, 'h208, 1'b1, 32'hFFFF_FDFF);
        // Immediates with bit 18 set sign extend
        addInstr(encI(cpu_pkg::OP_ADDI, 4, 1, -6));
        addStore(4, 'h209, 1'b1, 32'h0001_2340);
        addInstr(encI(cpu_pkg::OP_ANDI, 4, 2, 'h40FF0));
        addStore(4, 'h20A, 1'b1, 32'hFFFC_0FF0);
        addInstr(encI(cpu_pkg::OP_ORI, 4, 1, 'h40001));
        addStore(4, 'h20B, 1'b1, 32'hFFFD_2347);
        addInstr(encI(cpu_pkg::OP_NOT, 4, 1, 0));
        addStore(4, 'h20C, 1'b1, 32'hFFFE_DCB9);
        addInstr(encI(cpu_pkg::OP_NEG, 4, 1, 0));
        addStore(4, 'h20D, 1'b1, 32'hFFFE_DCBA);
        addInstr(encI(cpu_pkg::OP_LD, 4, 0, 'h300));
        addStore(4, 'h20E, 1'b1, fillWord(16'h0300));
        // R0 ignores the write
        addInstr(encI(cpu_pkg::OP_LI, 0, 0, 'h55));
        addStore(0, 'h20F, 1'b1, 32'h0);
        // Marker R5 flags a wrong path and R6 the right one
        addInstr(encI(cpu_pkg::OP_LI, 5, 0, 'hBAD));
        addInstr(encI(cpu_pkg::OP_LI, 6, 0, 'h600D));
        addInstr(encB(cpu_pkg::BR_ZERO, 0, 1));
        addStore(5, 'h210, 1'b0, '0);
        addInstr(encB(cpu_pkg::BR_ZERO, 1, 1));
        addStore(6, 'h210, 1'b1, 32'h600D);
        addInstr(encB(cpu_pkg::BR_NZERO, 1, 1));
        addStore(5, 'h211, 1'b0, '0);
        addInstr(encB(cpu_pkg::BR_NZERO, 0, 1));
        addStore(6, 'h211, 1'b1, 32'h600D);
        addInstr(encB(cpu_pkg::BR_POS, 1, 1));
        addStore(5, 'h212, 1'b0, '0);
        addInstr(encB(cpu_pkg::BR_POS, 2, 1));
        addStore(6, 'h212, 1'b1, 32'h600D);
        addInstr(encB(cpu_pkg::BR_NEG, 2, 1));
        addStore(5, 'h213, 1'b0, '0);
        addInstr(encB(cpu_pkg::BR_NEG, 1, 1));
        addStore(6, 'h213, 1'b1, 32'h600D);
        // Call into a routine placed past the halt
        jalAt = prog.size() + 1;
        addInstr(encI(cpu_pkg::OP_LI, 7, 0, jalAt + 5));
        addInstr(encJ(cpu_pkg::OP_JAL, 7));
        addStore(7, 'h214, 1'b1, jalAt + 1);
        addStore(8, 'h215, 1'b1, 32'h77);
        addInstr(encR(cpu_pkg::OP_HLT, 0, 0, 0));
        addStore(1, 'h216, 1'b0, '0);
        addInstr(encI(cpu_pkg::OP_ADDI, 8, 0, 'h77));
        addInstr(encJ(cpu_pkg::OP_JR, 7));
    endtask

    always #(CLK_PERIOD / 2) iClk = ~iClk;

    // Reads answer at once and only under the read strobe
    assign memRData = memRead ? mem[memAddr] : 'x;

    // Writes land at the rising edge
    always @(posedge iClk) begin
        if (memWrite && memRdy)
            mem[memAddr] <= memWData;
    end

    // Ready high three cycles in four with the fourth from the LFSR
    always @(negedge iClk) begin
        phase <= phase + 2'd1;
        if (phase == 2'd3) begin
            lfsr = lfsrStep(lfsr);
            memRdy <= lfsr[0];
        end else begin
            memRdy <= 1'b1;
        end
    end

    cpuCore cpuCore_inst (
        .iClk    (iClk),
        .nRst    (nRst),
        .memRdy  (memRdy),
        .memRData(memRData),
        .memAddr (memAddr),
        .memWData(memWData),
        .memRead (memRead),
        .memWrite(memWrite),
        .halted  (halted)
    );

    cpuCore_checker cpuCore_checker_inst (
        .iClk     (iClk),
        .nRst     (nRst),
        .memRdy   (memRdy),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWData (memWData),
        .halted   (halted),
        .valueErrs(valueErrs),
        .otherErrs(otherErrs),
        .done     (checkDone)
    );

    initial begin
        iClk = 1'b0;
        nRst = 1'b0;
        memRdy = 1'b0;
        lfsr = 32'h2691;
        phase = 2'd0;
        runLimit = 0;
        buildProgram();
        // Background first and then the program over the low words
        for (int a = 0; a < (1 << `CPU_ADDR_W); a++)
            mem[a] = fillWord(16'(a));
        for (int i = 0; i < prog.size(); i++) begin
            mem[i] = prog[i].instr;
            if (prog[i].chk)
                cpuCore_checker_inst.expectStore(prog[i].addr, prog[i].data);
        end
        runLimit = prog.size() * `CPU_STEPS * 4 * CLK_PERIOD + RST_CYCLES * CLK_PERIOD;
        repeat (RST_CYCLES) @(posedge iClk);
        @(negedge iClk);
        nRst = 1'b1;
        wait (checkDone === 1'b1);
        $display("Error counts: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Watchdog allows four cycles per step for stalls
    initial begin
        wait (runLimit != 0);
        #(runLimit);
        $display("Timeout: the core did not halt within %0d ns", runLimit);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
cpu_pkg.sv
cpuDecode.sv
cpuAlu.sv
cpuRegFile.sv
cpuControl.sv
cpuDatapath.sv
cpuCore.sv
cpuCore_props.sv
cpuCore_checker.sv
cpuCore_tb.sv

/* Bender.yml */
package:
  name: cpu_core

export_include_dirs:
  - .

sources:
  - files:
      - cpu_pkg.sv
      - cpuDecode.sv
      - cpuAlu.sv
      - cpuRegFile.sv
      - cpuControl.sv
      - cpuDatapath.sv
      - cpuCore.sv
  - target: test
    files:
      - cpuCore_props.sv
      - cpuCore_checker.sv
      - cpuCore_tb.sv
